/* verilog/hazardCtrl_cfg.svh */
`ifndef HAZARD_CTRL_CFG_SVH
`define HAZARD_CTRL_CFG_SVH

// datapath word, shared by instructions and PC values
`define HC_WORD_W 16

// four architectural registers
`define HC_REG_AW 2

// instruction field widths
`define HC_OPC_W 4
`define HC_FUNC_W 6

`endif

/* verilog/hazardCtrlPkg.sv */
`default_nettype none

`include "hazardCtrl_cfg.svh"

package hazardCtrlPkg;

	typedef logic [`HC_WORD_W-1:0] word_t;
	typedef logic [`HC_REG_AW-1:0] regAddr_t;

	typedef enum logic [`HC_OPC_W-1:0] {
		OP_BNE = 4'd0, OP_BEQ = 4'd1, OP_BGZ = 4'd2, OP_BLZ = 4'd3,
		OP_ADI = 4'd4, OP_ORI = 4'd5, OP_LHI = 4'd6, OP_LWD = 4'd7,
		OP_SWD = 4'd8, OP_JMP = 4'd9, OP_JAL = 4'd10, OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [`HC_FUNC_W-1:0] {
		FN_ADD = 6'd0, FN_SUB = 6'd1, FN_AND = 6'd2, FN_ORR = 6'd3,
		FN_NOT = 6'd4, FN_TCP = 6'd5, FN_SHL = 6'd6, FN_SHR = 6'd7,
		FN_JPR = 6'd25, FN_JRL = 6'd26, FN_HLT = 6'd29
	} func_e;

	typedef struct packed {
		opcode_e opcode;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		func_e func;
	} rType_t;

	typedef struct packed {
		opcode_e opcode;
		regAddr_t rs;
		regAddr_t rt;
		logic [`HC_WORD_W-`HC_OPC_W-2*`HC_REG_AW-1:0] imm; // 8-bit immediate
	} iType_t;

	// ID word, seen as R-type or I-type
	typedef union packed {
		rType_t rType;
		iType_t iType;
	} instWord_u;

	typedef struct packed {
		logic regWrite;
		regAddr_t dest;
	} stageDest_t;

	typedef enum logic [1:0] {KIND_NONE, KIND_BRANCH, KIND_JREG, KIND_JUMP} ctrlKind_e;

	typedef struct packed {
		regAddr_t rs;
		regAddr_t rt;
		logic usesRs;
		logic usesRt;
		logic isHalt;
		ctrlKind_e kind;
	} idInfo_t;

	typedef struct packed {
		logic iHit;
		logic dHit;
		logic iReady;
		logic dReady;
	} cacheStat_t;

	typedef struct packed {
		logic bcond;
		word_t brTarget; // taken branch address
		word_t jrTarget; // register value for JPR/JRL
		word_t jumpAddr;
		word_t predictedPc; // what IF fetched after this instruction
		word_t nextPc; // PC + 1
	} ctrlTargets_t;

	typedef enum logic [1:0] {FWD_NONE = 2'd0, FWD_EX = 2'd1, FWD_MEM = 2'd2, FWD_WB = 2'd3} fwdSel_e;

	typedef enum logic [1:0] {MODE_RUN, MODE_FRONT, MODE_LOADUSE, MODE_ALL} stallMode_e;

	typedef enum logic [1:0] {
		BTB_BR_TARGET = 2'd0, BTB_REG = 2'd1, BTB_JUMP = 2'd2, BTB_NEXT_PC = 2'd3
	} btbSrc_e;

	typedef struct packed {
		logic pcWrite;
		logic idWrite;
		logic exWrite;
		logic memWrite;
		logic wbWrite;
		logic flushEx; // load-use bubble into EX
	} stageCtrl_t;

	typedef struct packed {
		logic isPredict;
		logic flush;
		logic btbWrite;
		btbSrc_e btbSrc;
	} resolve_t;

	typedef enum logic [2:0] {
		MS_IDLE, MS_ACCESS_I, MS_ACCESS_D, MS_LOAD_STALL, MS_BOTH
	} missState_e;

endpackage

`default_nettype wire

/* verilog/instDecoder.sv */
`default_nettype none

module instDecoder import hazardCtrlPkg::*; (
	input instWord_u i_inst,
	output idInfo_t o_info
);

	opcode_e opc;
	func_e func;

	assign opc = i_inst.iType.opcode; // same bits in both views
	assign func = i_inst.rType.func; // only meaningful for RTYPE

	always_comb begin
		o_info.rs = i_inst.iType.rs;
		o_info.rt = i_inst.iType.rt;
		o_info.usesRs = 1'b0;
		o_info.usesRt = 1'b0;
		o_info.isHalt = 1'b0;
		o_info.kind = KIND_NONE;
		case (opc)
			OP_BNE, OP_BEQ: begin
				o_info.usesRs = 1'b1; // compares rs with rt
				o_info.usesRt = 1'b1;
				o_info.kind = KIND_BRANCH;
			end
			OP_BGZ, OP_BLZ: begin
				o_info.usesRs = 1'b1; // compares rs with zero
				o_info.kind = KIND_BRANCH;
			end
			OP_ADI, OP_ORI, OP_LWD: begin
				o_info.usesRs = 1'b1;
			end
			OP_SWD: begin
				o_info.usesRs = 1'b1; // base address
				o_info.usesRt = 1'b1; // store data
			end
			OP_JMP, OP_JAL: begin
				o_info.kind = KIND_JUMP;
			end
			OP_RTYPE: begin
				o_info.usesRs = (func != FN_HLT);
				o_info.usesRt = (func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR});
				o_info.isHalt = (func == FN_HLT);
				if (func inside {FN_JPR, FN_JRL}) begin
					o_info.kind = KIND_JREG;
				end
			end
			default: begin
				// LHI and unknown opcodes read no register
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/forwardUnit.sv */
`default_nettype none

module forwardUnit import hazardCtrlPkg::*; (
	input idInfo_t i_info,
	input opcode_e i_exOpcode,
	input stageDest_t i_exStage,
	input stageDest_t i_memStage,
	input stageDest_t i_wbStage,
	output fwdSel_e o_fwdA,
	output fwdSel_e o_fwdB,
	output logic o_loadUse
);

	// stage will write the register this source reads
	function automatic logic writesReg(input stageDest_t stage, input regAddr_t src);
		return stage.regWrite && (stage.dest == src);
	endfunction

	// youngest producer wins
	function automatic fwdSel_e pickFwd(input regAddr_t src, input logic used,
			input stageDest_t ex, input stageDest_t mem, input stageDest_t wb);
		fwdSel_e sel;
		sel = FWD_NONE;
		if (used) begin
			if (writesReg(ex, src)) begin
				sel = FWD_EX;
			end else if (writesReg(mem, src)) begin
				sel = FWD_MEM;
			end else if (writesReg(wb, src)) begin
				sel = FWD_WB;
			end
		end
		return sel;
	endfunction

	logic rsFromEx;
	logic rtFromEx;

	assign o_fwdA = pickFwd(i_info.rs, i_info.usesRs, i_exStage, i_memStage, i_wbStage);
	assign o_fwdB = pickFwd(i_info.rt, i_info.usesRt, i_exStage, i_memStage, i_wbStage);

	assign rsFromEx = i_info.usesRs && writesReg(i_exStage, i_info.rs);
	assign rtFromEx = i_info.usesRt && writesReg(i_exStage, i_info.rt);

	// load data not there until MEM, so ID waits a cycle
	assign o_loadUse = (i_exOpcode == OP_LWD) && (rsFromEx || rtFromEx);

endmodule

`default_nettype wire

/* verilog/missFsm.sv */
`default_nettype none

module missFsm import hazardCtrlPkg::*; (
	input logic clk,
	input logic reset_n,
	input cacheStat_t i_cache,
	input logic i_loadUse,
	output stallMode_e o_mode
);

	missState_e state;
	missState_e nextState;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= MS_IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		o_mode = MODE_RUN;
		case (state)
			MS_IDLE: begin
				if (!i_cache.dHit) begin
					o_mode = MODE_ALL; // data miss freezes everything
					nextState = MS_ACCESS_D;
				end else if (i_loadUse) begin
					o_mode = MODE_LOADUSE;
					nextState = MS_LOAD_STALL;
				end else if (!i_cache.iHit) begin
					o_mode = MODE_FRONT; // back end keeps draining
					nextState = MS_ACCESS_I;
				end
			end
			MS_ACCESS_I: begin
				if (!i_cache.dHit) begin
					o_mode = MODE_ALL;
					nextState = MS_BOTH;
				end else if (i_cache.iReady) begin
					nextState = MS_IDLE; // fetch line arrived
				end else begin
					o_mode = MODE_FRONT;
				end
			end
			MS_ACCESS_D: begin
				if (!i_cache.iHit) begin
					o_mode = MODE_ALL;
					nextState = MS_BOTH;
				end else if (i_cache.dReady) begin
					nextState = MS_IDLE;
				end else begin
					o_mode = MODE_ALL;
				end
			end
			MS_LOAD_STALL: begin
				// the load itself may miss in MEM
				if (!i_cache.dHit) begin
					o_mode = MODE_ALL;
					nextState = MS_ACCESS_D;
				end else begin
					nextState = MS_IDLE;
				end
			end
			MS_BOTH: begin
				if (i_cache.iReady && i_cache.dReady) begin
					nextState = MS_IDLE;
				end else begin
					o_mode = MODE_ALL; // wait for both refills
				end
			end
			default: begin
				o_mode = MODE_ALL;
				nextState = MS_IDLE; // unused encodings recover
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/pipeCtrl.sv */
`default_nettype none

module pipeCtrl import hazardCtrlPkg::*; (
	input stallMode_e i_mode,
	input idInfo_t i_info,
	input ctrlTargets_t i_targets,
	output stageCtrl_t o_stage,
	output resolve_t o_resolve
);

	localparam stageCtrl_t RUN_EN = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
	localparam stageCtrl_t FRONT_EN = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
	localparam stageCtrl_t LOADUSE_EN = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
	localparam stageCtrl_t ALL_EN = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

	logic resolveOk;
	word_t actualPc;

	// halt holds IF/ID but lets older instructions finish
	always_comb begin
		if (i_info.isHalt) begin
			o_stage = FRONT_EN;
		end else begin
			case (i_mode)
				MODE_FRONT: o_stage = FRONT_EN;
				MODE_LOADUSE: o_stage = LOADUSE_EN;
				MODE_ALL: o_stage = ALL_EN;
				default: o_stage = RUN_EN;
			endcase
		end
	end

	assign resolveOk = (i_mode == MODE_RUN) && !i_info.isHalt;

	always_comb begin
		o_resolve = '0;
		actualPc = i_targets.nextPc;
		if (resolveOk) begin
			case (i_info.kind)
				KIND_BRANCH: begin
					o_resolve.isPredict = 1'b1;
					if (i_targets.bcond) begin
						o_resolve.btbWrite = 1'b1; // learn the taken target
						o_resolve.btbSrc = BTB_BR_TARGET;
						actualPc = i_targets.brTarget;
					end else begin
						o_resolve.btbSrc = BTB_NEXT_PC;
					end
				end
				KIND_JREG: begin
					o_resolve.isPredict = 1'b1;
					o_resolve.btbWrite = 1'b1;
					o_resolve.btbSrc = BTB_REG;
					actualPc = i_targets.jrTarget;
				end
				KIND_JUMP: begin
					o_resolve.isPredict = 1'b1;
					o_resolve.btbWrite = 1'b1;
					o_resolve.btbSrc = BTB_JUMP;
					actualPc = i_targets.jumpAddr;
				end
				default: begin
				end
			endcase
			// wrong-path fetch in IF gets squashed
			o_resolve.flush = o_resolve.isPredict && (i_targets.predictedPc != actualPc);
		end
	end

endmodule

`default_nettype wire

/* verilog/hazardCtrl.sv */
`default_nettype none

module hazardCtrl import hazardCtrlPkg::*; (
	input logic clk,
	input logic reset_n,

	input instWord_u i_instId, // instruction in ID
	input opcode_e i_exOpcode,
	input stageDest_t i_exStage,
	input stageDest_t i_memStage,
	input stageDest_t i_wbStage,
	input cacheStat_t i_cache,
	input ctrlTargets_t i_targets,

	output fwdSel_e o_fwdA, // rs operand source
	output fwdSel_e o_fwdB, // rt operand source
	output stageCtrl_t o_stage,
	output resolve_t o_resolve
);

	idInfo_t idInfo;
	logic loadUse;
	stallMode_e mode;

	instDecoder decoder0 (
		.i_inst (i_instId),
		.o_info (idInfo)
	);

	forwardUnit forward0 (
		.i_info (idInfo),
		.i_exOpcode (i_exOpcode),
		.i_exStage (i_exStage),
		.i_memStage (i_memStage),
		.i_wbStage (i_wbStage),
		.o_fwdA (o_fwdA),
		.o_fwdB (o_fwdB),
		.o_loadUse (loadUse)
	);

	missFsm fsm0 (
		.clk (clk),
		.reset_n (reset_n),
		.i_cache (i_cache),
		.i_loadUse (loadUse),
		.o_mode (mode)
	);

	pipeCtrl ctrl0 (
		.i_mode (mode),
		.i_info (idInfo),
		.i_targets (i_targets),
		.o_stage (o_stage),
		.o_resolve (o_resolve)
	);

endmodule

`default_nettype wire

/* tests/hazardCtrl_sva.sv */
`default_nettype none

module hazardCtrlSva import hazardCtrlPkg::*; (
	input logic clk,
	input logic reset_n,
	input instWord_u i_instId,
	input cacheStat_t i_cache,
	input stageCtrl_t o_stage,
	input resolve_t o_resolve
);

	// BTB update and squash only come with a resolved control instruction
	predictOnly: assert property (@(posedge clk) disable iff (!reset_n)
		(o_resolve.btbWrite || o_resolve.flush) |-> o_resolve.isPredict)
		else $error("BTB write or flush without isPredict");

	// bubble into EX needs the front of the pipe frozen
	bubbleHoldsFront: assert property (@(posedge clk) disable iff (!reset_n)
		o_stage.flushEx |-> !(o_stage.pcWrite || o_stage.idWrite || o_stage.exWrite))
		else $error("flushEx while PC, ID or EX still enabled");

	// clean start out of reset
	runAfterReset: assert property (@(posedge clk)
		($rose(reset_n) && i_cache.iHit && i_cache.dHit && i_instId.iType.opcode == OP_ADI)
		|-> (o_stage.pcWrite && o_stage.idWrite && o_stage.exWrite
			&& o_stage.memWrite && o_stage.wbWrite))
		else $error("stage enables not all set after reset release");

endmodule

`default_nettype wire

/* tests/hazardCtrl_tb.sv */
`default_nettype none

module hazardCtrl_tb import hazardCtrlPkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 6;
	localparam logic [31:0] SEED = 32'he94d0dc8;

	// pcWrite, idWrite, exWrite, memWrite, wbWrite, flushEx
	localparam stageCtrl_t ST_RUN = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
	localparam stageCtrl_t ST_FRONT = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0}; // halt too
	localparam stageCtrl_t ST_LOADUSE = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
	localparam stageCtrl_t ST_ALL = '0;
	localparam resolve_t NO_RESOLVE = '0;
	localparam cacheStat_t HITS = '{1'b1, 1'b1, 1'b0, 1'b0};

	logic clk;
	logic reset_n;
	instWord_u instId;
	opcode_e exOpcode;
	stageDest_t exStage;
	stageDest_t memStage;
	stageDest_t wbStage;
	cacheStat_t cache;
	ctrlTargets_t targets;
	fwdSel_e fwdA;
	fwdSel_e fwdB;
	stageCtrl_t stage;
	resolve_t resolve;
	logic [31:0] rnd;

	hazardCtrl dut0 (
		.clk (clk),
		.reset_n (reset_n),
		.i_instId (instId),
		.i_exOpcode (exOpcode),
		.i_exStage (exStage),
		.i_memStage (memStage),
		.i_wbStage (wbStage),
		.i_cache (cache),
		.i_targets (targets),
		.o_fwdA (fwdA),
		.o_fwdB (fwdB),
		.o_stage (stage),
		.o_resolve (resolve)
	);

	bind hazardCtrl hazardCtrlSva sva0 (
		.clk (clk),
		.reset_n (reset_n),
		.i_instId (i_instId),
		.i_cache (i_cache),
		.o_stage (o_stage),
		.o_resolve (o_resolve)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic instWord_u makeR(input func_e fn, input regAddr_t rs, input regAddr_t rt,
			input regAddr_t rd);
		instWord_u w;
		w.rType.opcode = OP_RTYPE;
		w.rType.rs = rs;
		w.rType.rt = rt;
		w.rType.rd = rd;
		w.rType.func = fn;
		return w;
	endfunction

	function automatic instWord_u makeI(input opcode_e op, input regAddr_t rs, input regAddr_t rt);
		instWord_u w;
		w = '0;
		w.iType.opcode = op;
		w.iType.rs = rs;
		w.iType.rt = rt;
		return w;
	endfunction

	function automatic stageDest_t makeDest(input logic we, input regAddr_t d);
		stageDest_t s;
		s.regWrite = we;
		s.dest = d;
		return s;
	endfunction

	function automatic cacheStat_t makeCache(input logic ih, input logic dh, input logic ir,
			input logic dr);
		cacheStat_t c;
		c.iHit = ih;
		c.dHit = dh;
		c.iReady = ir;
		c.dReady = dr;
		return c;
	endfunction

	// youngest stage writing the source wins
	function automatic fwdSel_e expectFwd(input regAddr_t src, input logic used,
			input stageDest_t ex, input stageDest_t mem, input stageDest_t wb);
		fwdSel_e sel;
		sel = FWD_NONE;
		if (used && ex.regWrite && ex.dest == src) begin
			sel = FWD_EX;
		end else if (used && mem.regWrite && mem.dest == src) begin
			sel = FWD_MEM;
		end else if (used && wb.regWrite && wb.dest == src) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkStage(input string name, input stageCtrl_t got, input stageCtrl_t exp);
		if (got !== exp) begin
			abortRun($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, got));
		end
	endtask

	task automatic checkResolve(input string name, input resolve_t got, input resolve_t exp);
		if (got !== exp) begin
			abortRun($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, got));
		end
	endtask

	task automatic checkFwd(input string name, input fwdSel_e got, input fwdSel_e exp);
		if (got !== exp) begin
			abortRun($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, got));
		end
	endtask

	// one cycle with a new ID word and cache status, nothing to resolve
	task automatic stepCheck(input instWord_u inst, input cacheStat_t c, input stageCtrl_t exp);
		@(posedge clk);
		instId <= inst;
		cache <= c;
		@(negedge clk);
		checkStage("o_stage", stage, exp);
		checkResolve("o_resolve", resolve, NO_RESOLVE);
	endtask

	// quiet cycle, the pipe must be running again
	task automatic restoreIdle();
		@(posedge clk);
		instId <= makeI(OP_ADI, 2'd0, 2'd0);
		exOpcode <= OP_ADI;
		exStage <= makeDest(1'b0, 2'd0);
		memStage <= makeDest(1'b0, 2'd0);
		wbStage <= makeDest(1'b0, 2'd0);
		cache <= HITS;
		targets <= '0;
		@(negedge clk);
		checkStage("o_stage", stage, ST_RUN);
		checkResolve("o_resolve", resolve, NO_RESOLVE);
	endtask

	task automatic forwardCase(input instWord_u inst, input logic useRt, input stageDest_t ex,
			input stageDest_t mem, input stageDest_t wb);
		@(posedge clk);
		instId <= inst;
		exOpcode <= OP_ADI; // no load, so never a stall
		exStage <= ex;
		memStage <= mem;
		wbStage <= wb;
		@(negedge clk);
		checkFwd("o_fwdA", fwdA, expectFwd(inst.iType.rs, 1'b1, ex, mem, wb));
		checkFwd("o_fwdB", fwdB, expectFwd(inst.iType.rt, useRt, ex, mem, wb));
		checkStage("o_stage", stage, ST_RUN);
	endtask

	task automatic resolveCase(input instWord_u inst, input logic bcond, input btbSrc_e expSrc,
			input logic expWrite, input logic predictRight);
		ctrlTargets_t t;
		resolve_t exp;
		word_t actual;
		rnd = $urandom();
		t.bcond = bcond;
		t.brTarget = rnd[15:0];
		t.jrTarget = rnd[31:16];
		rnd = $urandom();
		t.jumpAddr = rnd[15:0];
		t.nextPc = rnd[31:16];
		case (expSrc)
			BTB_BR_TARGET: actual = t.brTarget;
			BTB_REG: actual = t.jrTarget;
			BTB_JUMP: actual = t.jumpAddr;
			default: actual = t.nextPc;
		endcase
		t.predictedPc = predictRight ? actual : ~actual;
		exp = '{1'b1, !predictRight, expWrite, expSrc};
		@(posedge clk);
		instId <= inst;
		targets <= t;
		@(negedge clk);
		checkResolve("o_resolve", resolve, exp);
		checkStage("o_stage", stage, ST_RUN);
	endtask

	task automatic testForwarding();
		instWord_u inst;
		stageDest_t ex;
		stageDest_t mem;
		stageDest_t wb;
		inst = makeR(FN_ADD, 2'd1, 2'd2, 2'd0);
		forwardCase(inst, 1'b1, makeDest(1'b1, 2'd1), makeDest(1'b1, 2'd1), makeDest(1'b1, 2'd1));
		forwardCase(inst, 1'b1, makeDest(1'b0, 2'd1), makeDest(1'b1, 2'd1), makeDest(1'b1, 2'd2));
		forwardCase(inst, 1'b1, makeDest(1'b1, 2'd3), makeDest(1'b1, 2'd0), makeDest(1'b1, 2'd1));
		for (int i = 0; i < 10; i++) begin
			rnd = $urandom();
			ex = makeDest(rnd[4], rnd[6:5]);
			mem = makeDest(rnd[7], rnd[9:8]);
			wb = makeDest(rnd[10], rnd[12:11]);
			forwardCase(makeR(FN_ADD, rnd[1:0], rnd[3:2], 2'd0), 1'b1, ex, mem, wb);
			forwardCase(makeI(OP_ORI, rnd[1:0], rnd[3:2]), 1'b0, ex, mem, wb); // rt unused
		end
		restoreIdle();
	endtask

	task automatic testLoadUse();
		@(posedge clk);
		instId <= makeR(FN_ADD, 2'd1, 2'd2, 2'd3);
		exOpcode <= OP_LWD;
		exStage <= makeDest(1'b1, 2'd1);
		@(negedge clk);
		checkStage("o_stage", stage, ST_LOADUSE);
		checkFwd("o_fwdA", fwdA, FWD_EX);
		@(posedge clk);
		exOpcode <= OP_ADI; // the load has moved on to MEM
		exStage <= makeDest(1'b0, 2'd0);
		memStage <= makeDest(1'b1, 2'd1);
		@(negedge clk);
		checkStage("o_stage", stage, ST_RUN);
		checkFwd("o_fwdA", fwdA, FWD_MEM);
		@(posedge clk);
		exOpcode <= OP_LWD; // now the rt operand
		exStage <= makeDest(1'b1, 2'd2);
		memStage <= makeDest(1'b0, 2'd0);
		@(negedge clk);
		checkStage("o_stage", stage, ST_LOADUSE);
		checkFwd("o_fwdB", fwdB, FWD_EX);
		restoreIdle();
		@(posedge clk);
		instId <= makeR(FN_ADD, 2'd1, 2'd2, 2'd3);
		exStage <= makeDest(1'b1, 2'd1); // ALU result, forwards without a stall
		@(negedge clk);
		checkStage("o_stage", stage, ST_RUN);
		checkFwd("o_fwdA", fwdA, FWD_EX);
		restoreIdle();
	endtask

	task automatic testInstThenDataMiss();
		instWord_u nop;
		nop = makeI(OP_ADI, 2'd0, 2'd0);
		stepCheck(nop, makeCache(1'b0, 1'b1, 1'b0, 1'b0), ST_FRONT);
		stepCheck(nop, makeCache(1'b0, 1'b0, 1'b0, 1'b0), ST_ALL);
		stepCheck(nop, makeCache(1'b0, 1'b0, 1'b1, 1'b0), ST_ALL);
		stepCheck(nop, makeCache(1'b0, 1'b0, 1'b0, 1'b1), ST_ALL);
		stepCheck(nop, makeCache(1'b1, 1'b1, 1'b1, 1'b1), ST_RUN);
		restoreIdle();
	endtask

	task automatic testDataMiss();
		instWord_u nop;
		nop = makeI(OP_ADI, 2'd0, 2'd0);
		stepCheck(nop, makeCache(1'b1, 1'b0, 1'b0, 1'b0), ST_ALL);
		repeat (3) stepCheck(nop, makeCache(1'b1, 1'b0, 1'b0, 1'b0), ST_ALL);
		stepCheck(nop, makeCache(1'b1, 1'b0, 1'b0, 1'b1), ST_RUN);
		restoreIdle();
	endtask

	task automatic testResolution();
		instWord_u beq;
		beq = makeI(OP_BEQ, 2'd1, 2'd2);
		resolveCase(beq, 1'b1, BTB_BR_TARGET, 1'b1, 1'b1);
		resolveCase(beq, 1'b1, BTB_BR_TARGET, 1'b1, 1'b0);
		resolveCase(beq, 1'b0, BTB_NEXT_PC, 1'b0, 1'b1);
		resolveCase(beq, 1'b0, BTB_NEXT_PC, 1'b0, 1'b0);
		resolveCase(makeR(FN_JPR, 2'd3, 2'd0, 2'd0), 1'b0, BTB_REG, 1'b1, 1'b1);
		resolveCase(makeR(FN_JPR, 2'd3, 2'd0, 2'd0), 1'b0, BTB_REG, 1'b1, 1'b0);
		resolveCase(makeI(OP_JAL, 2'd0, 2'd0), 1'b0, BTB_JUMP, 1'b1, 1'b1);
		resolveCase(makeI(OP_JAL, 2'd0, 2'd0), 1'b0, BTB_JUMP, 1'b1, 1'b0);
		// a branch held by a fetch stall is not resolved yet
		stepCheck(beq, makeCache(1'b0, 1'b1, 1'b0, 1'b0), ST_FRONT);
		stepCheck(makeI(OP_ADI, 2'd0, 2'd0), makeCache(1'b1, 1'b1, 1'b1, 1'b0), ST_RUN);
		restoreIdle();
	endtask

	task automatic testHalt();
		instWord_u hlt;
		hlt = makeR(FN_HLT, 2'd1, 2'd1, 2'd0);
		@(posedge clk);
		exStage <= makeDest(1'b1, 2'd1);
		targets <= '{1'b1, 16'h1234, 16'h2345, 16'h3456, 16'h4567, 16'h5678};
		stepCheck(hlt, HITS, ST_FRONT);
		checkFwd("o_fwdA", fwdA, FWD_NONE); // HLT reads no register
		stepCheck(hlt, makeCache(1'b1, 1'b0, 1'b0, 1'b0), ST_FRONT);
		stepCheck(hlt, makeCache(1'b1, 1'b0, 1'b0, 1'b0), ST_FRONT);
		stepCheck(hlt, makeCache(1'b1, 1'b1, 1'b0, 1'b1), ST_FRONT);
		restoreIdle();
	endtask

	initial begin
		watchdog();
	end

	task automatic watchdog();
		#(NUM_TESTS * 40 * CLK_PERIOD);
		abortRun("timeout: the tests did not finish in the expected time");
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		instId = makeI(OP_ADI, 2'd0, 2'd0);
		exOpcode = OP_ADI;
		exStage = '0;
		memStage = '0;
		wbStage = '0;
		cache = HITS;
		targets = '0;
		rnd = $urandom(SEED);
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		testForwarding();
		testLoadUse();
		testInstThenDataMiss();
		testDataMiss();
		testResolution();
		testHalt();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* hazardCtrl.f */
+incdir+verilog
verilog/hazardCtrlPkg.sv
verilog/instDecoder.sv
verilog/forwardUnit.sv
verilog/missFsm.sv
verilog/pipeCtrl.sv
verilog/hazardCtrl.sv
tests/hazardCtrl_sva.sv
tests/hazardCtrl_tb.sv

/* Makefile */
# Verilator build and run of the hazard controller testbench
TOP = hazardCtrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f hazardCtrl.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
